/* Bender.yml */
package:
  name: uart_cmd_bridge

sources:
  - uart_cmd_pkg.sv
  - uart_tx_frame.sv
  - uart_rx_frame.sv
  - uart_cmd_ctrl.sv
  - uart_cmd_bridge.sv
  - target: test
    files:
      - tb_uart_cmd_bridge.sv

/* compile.f */
uart_cmd_pkg.sv
uart_tx_frame.sv
uart_rx_frame.sv
uart_cmd_ctrl.sv
uart_cmd_bridge.sv
tb_uart_cmd_bridge.sv

/* tb_uart_cmd_bridge.sv */
`timescale 1ns/1ps

module tb_uart_cmd_bridge;

  localparam int CPB       = 8;
  localparam int GAP       = 20;
  localparam int FRAME_CYC = uart_cmd_pkg::FRAME_BITS * CPB;
  localparam int N_RANDOM  = 16;
  localparam int N_CMDS    = 5 + N_RANDOM;
  localparam int CYC_LIMIT = N_CMDS * (2 * FRAME_CYC + GAP + 200) + 100;

  logic                    clk;
  logic                    rst_n;
  uart_cmd_pkg::cmd_t      cmd_in;
  logic                    cmd_vld;
  logic                    cmd_rdy;
  logic                    rx;
  logic                    tx;
  logic                    read_rdy;
  uart_cmd_pkg::byte_t     read_data;
  logic                    read_err;

  int                      cyc_cnt;
  int                      errors;
  int                      checks;
  int                      n_tests;
  int                      n_reads;
  int                      rdy_pulses;
  int                      reply_req;
  logic [15:0]             lfsr_q;
  logic [1:0]              par_mode;  // 0 good, 1 inverted, 2 lfsr picks
  uart_cmd_pkg::byte_t     exp_q[$];
  logic [10:0]             got_q[$];
  uart_cmd_pkg::rx_frame_t reply_q[$];

  uart_cmd_bridge #(
    .CLKS_PER_BIT (CPB),
    .GAP_CYCLES   (GAP)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cyc_cnt <= cyc_cnt + 1;
    if (cyc_cnt >= CYC_LIMIT)
    begin
      $display("timeout: the run did not finish within %0d cycles", CYC_LIMIT);
      $display("Simulation FAILED");
      $finish;
    end
  end

  always @(negedge clk)
  begin
    if (rst_n && read_rdy === 1'b1)
      rdy_pulses++;
  end

  // galois form with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 16'hB400;
    return n;
  endfunction

  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);
    end
    return v;
  endfunction

  // bit 0 start, 1..8 data lsb first, 9 parity, 10 stop
  function automatic logic [10:0] ref_frame(input uart_cmd_pkg::byte_t b);
    int          ones;
    logic [10:0] f;
    ones = 0;
    f[0] = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      f[i+1] = b[i];
      ones   = ones + b[i];
    end
    f[9]  = (ones % 2 == 0);  // total ones odd
    f[10] = 1'b1;
    return f;
  endfunction

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  task automatic finish_test(input string name, input int err0);
    n_tests++;
    $display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "failed",
             errors - err0);
  endtask

  task automatic send_reply();
    uart_cmd_pkg::rx_frame_t rep;
    logic [10:0]             bits;
    rep.data = uart_cmd_pkg::byte_t'(rand_bits(8));
    if (par_mode == 2'd2)
      rep.parity_err = (rand_bits(1) != 0);
    else
      rep.parity_err = par_mode[0];
    bits = ref_frame(rep.data);
    if (rep.parity_err)
      bits[9] = ~bits[9];  // deliberately wrong
    reply_q.push_back(rep);
    repeat (6) @(negedge clk);
    for (int i = 0; i < uart_cmd_pkg::FRAME_BITS; i++)
    begin
      rx = bits[i];
      repeat (CPB) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  // peer decodes tx at mid-bit
  initial
  begin : peer_decode
    logic [10:0] f;
    int          start_cyc;
    int          cmd_start;
    bit          next_is_data;
    next_is_data = 1'b0;
    cmd_start    = 0;
    wait (rst_n === 1'b1);
    forever
    begin
      @(negedge tx);
      repeat (CPB / 2) @(posedge clk);
      @(negedge clk);
      start_cyc = cyc_cnt;
      f[0]      = tx;
      for (int i = 1; i < uart_cmd_pkg::FRAME_BITS; i++)
      begin
        repeat (CPB) @(negedge clk);
        f[i] = tx;
      end
      got_q.push_back(f);
      if (next_is_data)
      begin
        next_is_data = 1'b0;
        if (start_cyc - cmd_start - FRAME_CYC < GAP + 1)
          report_error("idle gap between write frames is too short");
      end
      else if (f[8])
      begin
        next_is_data = 1'b1;  // write so a data byte follows
        cmd_start    = start_cyc;
      end
      else
        reply_req++;
    end
  end

  initial
  begin : reply_driver
    forever
    begin
      @(negedge clk);
      if (reply_req > 0)
      begin
        reply_req--;
        send_reply();
      end
    end
  end

  always @(negedge clk)
  begin : frame_compare
    logic [10:0]         g;
    uart_cmd_pkg::byte_t e;
    if (got_q.size() > 0)
    begin
      g = got_q.pop_front();
      if (exp_q.size() == 0)
        report_error("a frame appeared on tx while no frame was expected");
      else
      begin
        e = exp_q.pop_front();
        compare_value(g, ref_frame(e), $sformatf("tx frame for byte %02h", e));
      end
    end
  end

  task automatic run_cmd(input uart_cmd_pkg::cmd_t c, input bit pulse_vld);
    int                      k;
    bit                      wr;
    uart_cmd_pkg::rx_frame_t rep;
    wr = c[15];
    exp_q.push_back(c[15:8]);
    if (wr)
      exp_q.push_back(c[7:0]);
    else
      n_reads++;
    if (cmd_rdy !== 1'b1)
      report_error("cmd_rdy was low when a new command was due");
    cmd_in  = c;
    cmd_vld = 1'b1;
    @(negedge clk);
    cmd_vld = 1'b0;
    k = 0;
    while (cmd_rdy !== 1'b1)
    begin
      if (read_rdy === 1'b1)
        report_error("read_rdy pulsed while cmd_rdy was low");
      cmd_vld = pulse_vld && (k % 37 == 5);  // must be ignored while busy
      cmd_in  = cmd_vld ? ~c : c;
      @(negedge clk);
      k++;
    end
    cmd_vld = 1'b0;
    cmd_in  = c;
    if (wr)
    begin
      compare_value(k, 2 * FRAME_CYC + GAP + 2, "write latency");
      compare_value(read_rdy, 0, "read_rdy after a write");
    end
    else
    begin
      compare_value(read_rdy, 1, "read_rdy together with cmd_rdy");
      if (reply_q.size() == 0)
        report_error("a read finished but the peer never replied");
      else
      begin
        rep = reply_q.pop_front();
        compare_value(read_data, rep.data, "read_data");
        compare_value(read_err, rep.parity_err, "read_err");
      end
    end
    @(negedge clk);
    compare_value(read_rdy, 0, "read_rdy pulse width");
    compare_value(exp_q.size(), 0, "tx frames still missing");
  endtask

  initial
  begin : stimulus
    uart_cmd_pkg::cmd_t c;
    int                 err0;
    rst_n      = 1'b0;
    cmd_in     = '0;
    cmd_vld    = 1'b0;
    rx         = 1'b1;
    lfsr_q     = 16'h0001;
    par_mode   = 2'd0;
    cyc_cnt    = 0;
    reply_req  = 0;
    errors     = 0;
    checks     = 0;
    n_tests    = 0;
    n_reads    = 0;
    rdy_pulses = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    err0 = errors;
    compare_value(tx, 1, "tx after reset");
    compare_value(cmd_rdy, 1, "cmd_rdy after reset");
    compare_value(read_rdy, 0, "read_rdy after reset");
    compare_value(read_err, 0, "read_err after reset");
    finish_test("reset", err0);

    err0 = errors;
    c = rand_bits(16);
    c[15] = 1'b1;
    run_cmd(c, 1'b0);
    finish_test("write", err0);

    err0 = errors;
    c = rand_bits(16);
    c[15] = 1'b0;
    run_cmd(c, 1'b0);
    finish_test("read", err0);

    err0 = errors;
    par_mode = 2'd1;
    c = rand_bits(16);
    c[15] = 1'b0;
    run_cmd(c, 1'b0);
    finish_test("read with bad parity", err0);

    err0 = errors;
    par_mode = 2'd0;
    c = rand_bits(16);
    run_cmd({1'b1, c[14:0]}, 1'b1);
    run_cmd({1'b0, c[14:0]}, 1'b1);
    finish_test("cmd_vld while busy", err0);

    err0 = errors;
    par_mode = 2'd2;
    for (int i = 0; i < N_RANDOM; i++)
      run_cmd(rand_bits(16), 1'b0);
    compare_value(rdy_pulses, n_reads, "read_rdy pulse count");
    finish_test("mixed commands", err0);

    $display("tests %0d, checks %0d, errors %0d", n_tests, checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

/* uart_cmd_bridge.sv */
`timescale 1ns/1ps

module uart_cmd_bridge #(
  parameter int CLKS_PER_BIT = 434,
  parameter int GAP_CYCLES   = 100
) (
  input  logic                clk,
  input  logic                rst_n,
  input  uart_cmd_pkg::cmd_t  cmd_in,
  input  logic                cmd_vld,
  output logic                cmd_rdy,
  input  logic                rx,
  output logic                tx,
  output logic                read_rdy,
  output uart_cmd_pkg::byte_t read_data,
  output logic                read_err
);

  logic                    tx_start;
  uart_cmd_pkg::byte_t     tx_data;
  logic                    tx_busy;
  logic                    rx_valid;
  uart_cmd_pkg::rx_frame_t rx_frame;

  uart_cmd_ctrl #(
    .GAP_CYCLES (GAP_CYCLES)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx_start  (tx_start),
    .tx_data   (tx_data),
    .tx_busy   (tx_busy),
    .rx_valid  (rx_valid),
    .rx_frame  (rx_frame),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_err  (read_err)
  );

  uart_tx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_start (tx_start),
    .tx_data  (tx_data),
    .tx_busy  (tx_busy),
    .tx       (tx)
  );

  // runs all the time, ctrl only listens in await_read
  uart_rx_frame #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_valid (rx_valid),
    .rx_frame (rx_frame)
  );

endmodule

/* uart_cmd_ctrl.sv */
`timescale 1ns/1ps

module uart_cmd_ctrl #(
  parameter int GAP_CYCLES = 100
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  uart_cmd_pkg::cmd_t      cmd_in,
  input  logic                    cmd_vld,
  output logic                    cmd_rdy,
  output logic                    tx_start,
  output uart_cmd_pkg::byte_t     tx_data,
  input  logic                    tx_busy,
  input  logic                    rx_valid,
  input  uart_cmd_pkg::rx_frame_t rx_frame,
  output logic                    read_rdy,
  output uart_cmd_pkg::byte_t     read_data,
  output logic                    read_err
);

  localparam int GAP_W = $clog2(GAP_CYCLES + 1);

  uart_cmd_pkg::ctrl_state_e state;
  uart_cmd_pkg::cmd_t        cmd_q;
  logic [GAP_W-1:0]          gap_cnt;
  logic                      accept;
  logic                      frame_done;
  logic                      gap_done;
  logic                      is_write;
  logic                      read_hit;

  assign accept     = cmd_vld && cmd_rdy;
  assign frame_done = !tx_busy && !tx_start;  // busy not yet up while start is pending
  assign gap_done   = (state == uart_cmd_pkg::GAP) && (gap_cnt == GAP_W'(GAP_CYCLES - 1));
  assign is_write   = cmd_q[uart_cmd_pkg::CMD_RW_BIT];
  assign read_hit   = (state == uart_cmd_pkg::AWAIT_READ) && rx_valid;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state    <= uart_cmd_pkg::IDLE;
      gap_cnt  <= '0;
      tx_start <= 1'b0;
      cmd_rdy  <= 1'b1;
      read_rdy <= 1'b0;
      read_err <= 1'b0;
    end
    else
    begin
      tx_start <= 1'b0;
      read_rdy <= 1'b0;
      case (state)
        uart_cmd_pkg::IDLE:
        begin
          if (accept)
          begin
            state    <= uart_cmd_pkg::SEND_CMD;
            tx_start <= 1'b1;  // command byte
            cmd_rdy  <= 1'b0;
            gap_cnt  <= '0;
          end
        end
        uart_cmd_pkg::SEND_CMD:
        begin
          if (frame_done)
          begin
            state <= is_write ? uart_cmd_pkg::GAP : uart_cmd_pkg::AWAIT_READ;
          end
        end
        uart_cmd_pkg::GAP:
        begin
          if (gap_done)
          begin
            state    <= uart_cmd_pkg::SEND_DATA;
            tx_start <= 1'b1;
          end
          else
          begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        uart_cmd_pkg::SEND_DATA:
        begin
          if (frame_done)
          begin
            state   <= uart_cmd_pkg::IDLE;
            cmd_rdy <= 1'b1;
          end
        end
        uart_cmd_pkg::AWAIT_READ:
        begin
          if (rx_valid)
          begin
            state    <= uart_cmd_pkg::IDLE;
            cmd_rdy  <= 1'b1;  // same cycle as read_rdy
            read_rdy <= 1'b1;
            read_err <= rx_frame.parity_err;
          end
        end
        default:
        begin
          state   <= uart_cmd_pkg::IDLE;
          cmd_rdy <= 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == uart_cmd_pkg::IDLE && accept)
    begin
      cmd_q   <= cmd_in;
      tx_data <= cmd_in[15:8];
    end
    else if (gap_done)
    begin
      tx_data <= cmd_q[7:0];
    end
    if (read_hit)
    begin
      read_data <= rx_frame.data;
    end
  end

  a_rdy_only_idle: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state != uart_cmd_pkg::IDLE) |-> !cmd_rdy
  );

  a_read_rdy_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy
  );

endmodule

/* uart_cmd_pkg.sv */
package uart_cmd_pkg;

  // frame is start, 8 data bits lsb first, odd parity, stop
  localparam int FRAME_BITS = 11;

  localparam int CMD_RW_BIT = 15;  // 1 write, 0 read

  typedef logic [15:0] cmd_t;      // {rw, addr[6:0], wdata[7:0]}
  typedef logic [7:0]  byte_t;
  typedef logic [3:0]  bit_idx_t;  // 0 start .. 10 stop

  localparam bit_idx_t PAR_IDX  = bit_idx_t'(FRAME_BITS - 2);
  localparam bit_idx_t STOP_IDX = bit_idx_t'(FRAME_BITS - 1);

  typedef struct packed {
    byte_t data;
    logic  parity_err;  // parity mismatch or low stop bit
  } rx_frame_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_CMD,   // command byte on the line
    GAP,        // write only
    SEND_DATA,
    AWAIT_READ  // no timeout
  } ctrl_state_e;

endpackage

/* uart_rx_frame.sv */
`timescale 1ns/1ps

module uart_rx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    rx,
  output logic                    rx_valid,
  output uart_cmd_pkg::rx_frame_t rx_frame
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
  localparam int HALF  = (CLKS_PER_BIT > 1) ? CLKS_PER_BIT / 2 : 1;

  logic                   rx_meta;
  logic                   rx_sync;
  logic                   rx_prev;
  logic                   active;
  logic [CNT_W-1:0]       baud_cnt;
  uart_cmd_pkg::bit_idx_t bit_idx;
  uart_cmd_pkg::byte_t    shift_q;
  logic                   par_q;
  logic                   start_edge;
  logic                   sample;
  logic                   is_data;

  assign start_edge = !active && rx_prev && !rx_sync;

  // start bit checked at half a bit, the rest one bit apart
  assign sample = active && ((bit_idx == '0) ? (baud_cnt == CNT_W'(HALF - 1))
                                             : (baud_cnt == CNT_W'(CLKS_PER_BIT - 1)));

  assign is_data = (bit_idx != '0) && (bit_idx < uart_cmd_pkg::PAR_IDX);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end
    else
    begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end
    else
    begin
      rx_valid <= 1'b0;
      if (start_edge)
      begin
        active   <= 1'b1;
        baud_cnt <= '0;
        bit_idx  <= '0;
      end
      else if (sample)
      begin
        baud_cnt <= '0;
        if (bit_idx == '0 && rx_sync)
        begin
          active <= 1'b0;  // glitch, not a start bit
        end
        else if (bit_idx == uart_cmd_pkg::STOP_IDX)
        begin
          active   <= 1'b0;
          bit_idx  <= '0;
          rx_valid <= 1'b1;  // mid stop bit
        end
        else
        begin
          bit_idx <= bit_idx + 1'b1;
        end
      end
      else if (active)
      begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (sample)
    begin
      if (is_data)
      begin
        shift_q <= {rx_sync, shift_q[7:1]};  // lsb first
      end
      if (bit_idx == uart_cmd_pkg::PAR_IDX)
      begin
        par_q <= rx_sync;
      end
      if (bit_idx == uart_cmd_pkg::STOP_IDX)
      begin
        rx_frame.data       <= shift_q;
        rx_frame.parity_err <= ~^{shift_q, par_q} | !rx_sync;
      end
    end
  end

  a_valid_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid
  );

endmodule

/* uart_tx_frame.sv */
`timescale 1ns/1ps

module uart_tx_frame #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                tx_start,
  input  uart_cmd_pkg::byte_t tx_data,
  output logic                tx_busy,
  output logic                tx
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic                   active;
  logic [CNT_W-1:0]       baud_cnt;
  uart_cmd_pkg::bit_idx_t bit_idx;
  logic [9:0]             shift_q;  // data, parity, stop still to go
  logic                   load;
  logic                   bit_end;
  logic                   last_clk;

  assign load     = tx_start && !active;
  assign bit_end  = active && (baud_cnt == CNT_W'(CLKS_PER_BIT - 1));
  assign last_clk = bit_end && (bit_idx == uart_cmd_pkg::STOP_IDX);

  // busy already low during the final stop clock
  assign tx_busy = active && !last_clk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      active   <= 1'b0;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b1;
    end
    else if (load)
    begin
      active   <= 1'b1;
      baud_cnt <= '0;
      bit_idx  <= '0;
      tx       <= 1'b0;  // start bit
    end
    else if (bit_end)
    begin
      baud_cnt <= '0;
      if (bit_idx == uart_cmd_pkg::STOP_IDX)
      begin
        active  <= 1'b0;
        bit_idx <= '0;
      end
      else
      begin
        bit_idx <= bit_idx + 1'b1;
        tx      <= shift_q[0];
      end
    end
    else if (active)
    begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (load)
    begin
      shift_q <= {1'b1, ~^tx_data, tx_data};  // odd parity
    end
    else if (bit_end)
    begin
      shift_q <= {1'b1, shift_q[9:1]};
    end
  end

  // controller must wait for the whole frame, last stop clock included
  a_no_start_while_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    tx_start |-> !active
  );

endmodule
